//--- cpuPkg.sv
package cpuPkg;

    localparam int DataWidth     = 32;
    localparam int RegAddrWidth  = 5;
    localparam int ImemDepth     = 64;
    localparam int DmemDepth     = 256;
    localparam int ImemAddrWidth = $clog2(ImemDepth);
    localparam int DmemAddrWidth = $clog2(DmemDepth);

    localparam int OpWidth     = 6;
    localparam int FnWidth     = 6;
    localparam int ShamtWidth  = 5;
    localparam int ImmWidth    = 16;
    localparam int TargetWidth = 26;

    // primary opcodes.
    localparam logic [OpWidth-1:0] OpRType = 6'h00;
    localparam logic [OpWidth-1:0] OpJ     = 6'h02;
    localparam logic [OpWidth-1:0] OpBeq   = 6'h04;
    localparam logic [OpWidth-1:0] OpAddi  = 6'h08;
    localparam logic [OpWidth-1:0] OpLw    = 6'h23;
    localparam logic [OpWidth-1:0] OpSw    = 6'h2b;

    // r-type funct field.
    localparam logic [FnWidth-1:0] FnAdd = 6'h20;
    localparam logic [FnWidth-1:0] FnSub = 6'h22;
    localparam logic [FnWidth-1:0] FnAnd = 6'h24;
    localparam logic [FnWidth-1:0] FnOr  = 6'h25;
    localparam logic [FnWidth-1:0] FnSlt = 6'h2a;

    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluSlt = 3'd4
    } aluOpE;

    typedef struct packed {
        logic [OpWidth-1:0]      op;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] rd;
        logic [ShamtWidth-1:0]   shamt;
        logic [FnWidth-1:0]      funct;
    } rTypeS;

    typedef struct packed {
        logic [OpWidth-1:0]      op;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [ImmWidth-1:0]     imm;
    } iTypeS;

    typedef struct packed {
        logic [OpWidth-1:0]     op;
        logic [TargetWidth-1:0] target;
    } jTypeS;

    // one fetched word, three views of it.
    typedef union packed {
        rTypeS rType;
        iTypeS iType;
        jTypeS jType;
    } instrU;

    typedef struct packed {
        logic  regWrite;
        logic  regDst;
        logic  aluSrc;
        logic  memWrite;
        logic  memToReg;
        logic  branch;
        logic  jump;
        aluOpE aluOp;
    } ctrlS;

    typedef struct packed {
        logic                    valid;
        logic [RegAddrWidth-1:0] index;
        logic [DataWidth-1:0]    data;
    } regTraceS;

    typedef struct packed {
        logic                     valid;
        logic [DmemAddrWidth-1:0] addr;   // word address.
        logic [DataWidth-1:0]     data;
    } storeTraceS;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpuPkg::DataWidth-1:0] i_a,
    input  logic [cpuPkg::DataWidth-1:0] i_b,
    input  cpuPkg::aluOpE                i_op,
    output logic [cpuPkg::DataWidth-1:0] o_result,
    output logic                         o_zero
);

    logic [cpuPkg::DataWidth-1:0] result;

    always_comb begin
        case (i_op)
            cpuPkg::AluAdd: begin
                result = i_a + i_b;
            end
            cpuPkg::AluSub: begin
                result = i_a - i_b;
            end
            cpuPkg::AluAnd: begin
                result = i_a & i_b;
            end
            cpuPkg::AluOr: begin
                result = i_a | i_b;
            end
            cpuPkg::AluSlt: begin
                // signed compare.
                result = {{(cpuPkg::DataWidth-1){1'b0}}, ($signed(i_a) < $signed(i_b))};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign o_result = result;
    assign o_zero   = (result == '0);

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                            i_clk,
    input  logic [cpuPkg::RegAddrWidth-1:0] i_rs,
    input  logic [cpuPkg::RegAddrWidth-1:0] i_rt,
    input  logic                            i_we,
    input  logic [cpuPkg::RegAddrWidth-1:0] i_wIdx,
    input  logic [cpuPkg::DataWidth-1:0]    i_wData,
    output logic [cpuPkg::DataWidth-1:0]    o_rsData,
    output logic [cpuPkg::DataWidth-1:0]    o_rtData
);

    localparam int NumRegs = 2 ** cpuPkg::RegAddrWidth;

    logic [cpuPkg::DataWidth-1:0] regs [NumRegs];

    always_ff @(posedge i_clk) begin
        if (i_we && (i_wIdx != '0)) begin
            regs[i_wIdx] <= i_wData;
        end
    end

    // $zero reads as zero, never stored.
    assign o_rsData = (i_rs == '0) ? '0 : regs[i_rs];
    assign o_rtData = (i_rt == '0) ? '0 : regs[i_rt];

endmodule

//--- pcUnit.sv
`timescale 1ns/1ps

module pcUnit (
    input  logic                         i_clk,
    input  logic                         i_rstN,
    input  cpuPkg::ctrlS                 i_ctrl,
    input  logic                         i_zero,
    input  cpuPkg::instrU                i_instr,
    output logic [cpuPkg::DataWidth-1:0] o_pc
);

    logic [cpuPkg::DataWidth-1:0] pc;
    logic [cpuPkg::DataWidth-1:0] pcPlus4;
    logic [cpuPkg::DataWidth-1:0] branchOff;
    logic [cpuPkg::DataWidth-1:0] branchTarget;
    logic [cpuPkg::DataWidth-1:0] jumpTarget;
    logic [cpuPkg::DataWidth-1:0] nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchOff    = {{(cpuPkg::DataWidth-cpuPkg::ImmWidth-2){i_instr.iType.imm[cpuPkg::ImmWidth-1]}},
                           i_instr.iType.imm, 2'b00};
    assign branchTarget = pcPlus4 + branchOff;
    assign jumpTarget   = {pcPlus4[31:28], i_instr.jType.target, 2'b00};   // pseudo-direct.

    always_comb begin
        if (i_ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (i_ctrl.branch && i_zero) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    assign o_pc = pc;

endmodule

//--- controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic          i_rstN,
    input  cpuPkg::instrU i_instr,
    output cpuPkg::ctrlS  o_ctrl
);

    cpuPkg::ctrlS ctrl;

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = cpuPkg::AluAdd;

        case (i_instr.rType.op)
            cpuPkg::OpRType: begin
                ctrl.regDst = 1'b1;
                ctrl.regWrite = 1'b1;
                case (i_instr.rType.funct)
                    cpuPkg::FnAdd: ctrl.aluOp = cpuPkg::AluAdd;
                    cpuPkg::FnSub: ctrl.aluOp = cpuPkg::AluSub;
                    cpuPkg::FnAnd: ctrl.aluOp = cpuPkg::AluAnd;
                    cpuPkg::FnOr:  ctrl.aluOp = cpuPkg::AluOr;
                    cpuPkg::FnSlt: ctrl.aluOp = cpuPkg::AluSlt;
                    default: begin
                        ctrl.regWrite = 1'b0;   // unknown funct is a no-op.
                    end
                endcase
            end
            cpuPkg::OpAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            cpuPkg::OpLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            cpuPkg::OpSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            cpuPkg::OpBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = cpuPkg::AluSub;   // compare via zero flag.
            end
            cpuPkg::OpJ: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase

        // no state changes while held in reset.
        if (!i_rstN) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

    assign o_ctrl = ctrl;

endmodule

//--- instrMem.sv
`timescale 1ns/1ps

module instrMem (
    input  logic [cpuPkg::DataWidth-1:0] i_pc,
    output cpuPkg::instrU                o_instr
);

    logic [cpuPkg::DataWidth-1:0] rom [cpuPkg::ImemDepth];

    initial begin
        for (int k = 0; k < cpuPkg::ImemDepth; k++) begin
            rom[k] = '0;   // unused words decode as no-op.
        end
        $readmemh("program.hex", rom);
    end

    assign o_instr = rom[i_pc[cpuPkg::ImemAddrWidth+1:2]];

endmodule

//--- dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic                             i_clk,
    input  logic                             i_we,
    input  logic [cpuPkg::DmemAddrWidth-1:0] i_addr,
    input  logic [cpuPkg::DataWidth-1:0]     i_wData,
    output logic [cpuPkg::DataWidth-1:0]     o_rData
);

    logic [cpuPkg::DataWidth-1:0] mem [cpuPkg::DmemDepth];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wData;
        end
    end

    assign o_rData = mem[i_addr];   // async read.

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic                       i_clk,
    input  logic                       i_rstN,
    output logic [cpuPkg::DataWidth-1:0] o_pc,
    output cpuPkg::regTraceS           o_regTrace,
    output cpuPkg::storeTraceS         o_storeTrace
);

    logic [cpuPkg::DataWidth-1:0]    pc;
    cpuPkg::instrU                   instr;
    cpuPkg::ctrlS                    ctrl;
    logic [cpuPkg::RegAddrWidth-1:0] wIdx;
    logic [cpuPkg::DataWidth-1:0]    rsData;
    logic [cpuPkg::DataWidth-1:0]    rtData;
    logic [cpuPkg::DataWidth-1:0]    signExtImm;
    logic [cpuPkg::DataWidth-1:0]    aluB;
    logic [cpuPkg::DataWidth-1:0]    aluResult;
    logic                            aluZero;
    logic [cpuPkg::DataWidth-1:0]    memData;
    logic [cpuPkg::DataWidth-1:0]    wData;
    logic [cpuPkg::DmemAddrWidth-1:0] memAddr;

    assign signExtImm = {{(cpuPkg::DataWidth-cpuPkg::ImmWidth){instr.iType.imm[cpuPkg::ImmWidth-1]}},
                         instr.iType.imm};

    assign wIdx    = ctrl.regDst ? instr.rType.rd : instr.rType.rt;
    assign aluB    = ctrl.aluSrc ? signExtImm : rtData;
    assign memAddr = aluResult[cpuPkg::DmemAddrWidth+1:2];   // byte address to word.
    assign wData   = ctrl.memToReg ? memData : aluResult;

    pcUnit u_pcUnit (
        .i_clk      (i_clk      ),
        .i_rstN     (i_rstN     ),
        .i_ctrl     (ctrl       ),
        .i_zero     (aluZero    ),
        .i_instr    (instr      ),
        .o_pc       (pc         )
    );

    instrMem u_instrMem (
        .i_pc       (pc         ),
        .o_instr    (instr      )
    );

    controlUnit u_controlUnit (
        .i_rstN     (i_rstN     ),
        .i_instr    (instr      ),
        .o_ctrl     (ctrl       )
    );

    regFile u_regFile (
        .i_clk      (i_clk             ),
        .i_rs       (instr.rType.rs    ),
        .i_rt       (instr.rType.rt    ),
        .i_we       (ctrl.regWrite     ),
        .i_wIdx     (wIdx              ),
        .i_wData    (wData             ),
        .o_rsData   (rsData            ),
        .o_rtData   (rtData            )
    );

    alu u_alu (
        .i_a        (rsData     ),
        .i_b        (aluB       ),
        .i_op       (ctrl.aluOp ),
        .o_result   (aluResult  ),
        .o_zero     (aluZero    )
    );

    dataMem u_dataMem (
        .i_clk      (i_clk         ),
        .i_we       (ctrl.memWrite ),
        .i_addr     (memAddr       ),
        .i_wData    (rtData        ),
        .o_rData    (memData       )
    );

    // observation only.
    assign o_pc               = pc;
    assign o_regTrace.valid   = ctrl.regWrite;
    assign o_regTrace.index   = wIdx;
    assign o_regTrace.data    = wData;
    assign o_storeTrace.valid = ctrl.memWrite;
    assign o_storeTrace.addr  = memAddr;
    assign o_storeTrace.data  = rtData;

endmodule

//--- tbIsaModel.sv
`timescale 1ns/1ps

module tbIsaModel (
    input  logic                         i_clk,
    input  logic                         i_rstN,
    output logic [cpuPkg::DataWidth-1:0] o_pc,
    output cpuPkg::regTraceS             o_regTrace,
    output cpuPkg::storeTraceS           o_storeTrace
);

    logic [31:0] imem [64];
    logic [31:0] regs [32];
    logic [31:0] dmem [256];
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] word;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] immExt;
    logic [31:0] effAddr;
    logic [31:0] seqPc;

    initial begin
        for (int k = 0; k < 64; k++) begin
            imem[k] = '0;
        end
        $readmemh("program.hex", imem);
    end

    // one whole instruction per cycle, straight from the ISA rules.
    always_comb begin
        word    = imem[pc[7:2]];
        immExt  = {{16{word[15]}}, word[15:0]};
        opA     = (word[25:21] == 5'd0) ? 32'd0 : regs[word[25:21]];
        opB     = (word[20:16] == 5'd0) ? 32'd0 : regs[word[20:16]];
        effAddr = opA + immExt;
        seqPc   = pc + 32'd4;
        nextPc  = seqPc;
        o_regTrace   = '0;
        o_storeTrace = '0;

        case (word[31:26])
            cpuPkg::OpRType: begin
                o_regTrace.valid = 1'b1;
                o_regTrace.index = word[15:11];
                case (word[5:0])
                    cpuPkg::FnAdd: o_regTrace.data = opA + opB;
                    cpuPkg::FnSub: o_regTrace.data = opA - opB;
                    cpuPkg::FnAnd: o_regTrace.data = opA & opB;
                    cpuPkg::FnOr:  o_regTrace.data = opA | opB;
                    cpuPkg::FnSlt: o_regTrace.data = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
                    default:       o_regTrace.valid = 1'b0;
                endcase
            end
            cpuPkg::OpAddi: begin
                o_regTrace = {1'b1, word[20:16], effAddr};
            end
            cpuPkg::OpLw: begin
                o_regTrace = {1'b1, word[20:16], dmem[effAddr[9:2]]};
            end
            cpuPkg::OpSw: begin
                o_storeTrace = {1'b1, effAddr[9:2], opB};
            end
            cpuPkg::OpBeq: begin
                if (opA == opB) begin
                    nextPc = seqPc + {immExt[29:0], 2'b00};
                end
            end
            cpuPkg::OpJ: begin
                nextPc = {seqPc[31:28], word[25:0], 2'b00};
            end
            default: begin
                nextPc = seqPc;   // anything else just falls through.
            end
        endcase

        if (!i_rstN) begin
            o_regTrace.valid   = 1'b0;
            o_storeTrace.valid = 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            pc <= '0;
        end else begin
            if (o_regTrace.valid && (o_regTrace.index != 5'd0)) begin
                regs[o_regTrace.index] <= o_regTrace.data;
            end
            if (o_storeTrace.valid) begin
                dmem[o_storeTrace.addr] <= o_storeTrace.data;
            end
            pc <= nextPc;
        end
    end

    assign o_pc = pc;

endmodule

//--- tbCpu.sv
`timescale 1ns/1ps

module tbCpu;

    localparam int ClkPeriod   = 10;
    localparam int ResetCycles = 16;
    localparam int PulseCycles = 3;
    localparam int ProgWords   = 32;
    localparam int HaltCycles  = 5;
    localparam int WatchdogNs  = (ResetCycles + PulseCycles + 4 * ProgWords + 20) * ClkPeriod;
    localparam logic [31:0] HaltPc = 32'h0000_007c;   // self-jump at the end of program.hex.

    logic                         clk;
    logic                         rstN;
    logic                         primed;
    logic [cpuPkg::DataWidth-1:0] pc;
    cpuPkg::regTraceS             regTrace;
    cpuPkg::storeTraceS           storeTrace;
    logic [cpuPkg::DataWidth-1:0] expPc;
    cpuPkg::regTraceS             expReg;
    cpuPkg::storeTraceS           expStore;

    cpu uut (
        .i_clk        (clk        ),
        .i_rstN       (rstN       ),
        .o_pc         (pc         ),
        .o_regTrace   (regTrace   ),
        .o_storeTrace (storeTrace )
    );

    tbIsaModel model (
        .i_clk        (clk        ),
        .i_rstN       (rstN       ),
        .o_pc         (expPc      ),
        .o_regTrace   (expReg     ),
        .o_storeTrace (expStore   )
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic reportMismatch(input string what);
        $display("Mismatch at %0t ns: %s", $time, what);
        $display("Test failed");
        $fatal(1, "lockstep check failed");
    endtask

    resetPc: assert property (@(posedge clk) !rstN |=> pc == '0)
        else reportMismatch($sformatf("pc after reset is %h", $sampled(pc)));

    resetQuiet: assert property (@(posedge clk) !rstN |-> !regTrace.valid && !storeTrace.valid)
        else reportMismatch("trace valid set while in reset");

    pcMatch: assert property (@(posedge clk) primed |-> pc == expPc)
        else reportMismatch($sformatf("pc dut %h model %h", $sampled(pc), $sampled(expPc)));

    regValidMatch: assert property (@(posedge clk) primed |-> regTrace.valid == expReg.valid)
        else reportMismatch($sformatf("reg write valid dut %b model %b at pc %h",
                                      $sampled(regTrace.valid), $sampled(expReg.valid),
                                      $sampled(pc)));

    regWriteMatch: assert property (@(posedge clk)
        regTrace.valid |-> regTrace.index == expReg.index && regTrace.data == expReg.data)
        else reportMismatch($sformatf("reg write dut r%0d=%h model r%0d=%h",
                                      $sampled(regTrace.index), $sampled(regTrace.data),
                                      $sampled(expReg.index), $sampled(expReg.data)));

    storeValidMatch: assert property (@(posedge clk) primed |-> storeTrace.valid == expStore.valid)
        else reportMismatch($sformatf("store valid dut %b model %b at pc %h",
                                      $sampled(storeTrace.valid), $sampled(expStore.valid),
                                      $sampled(pc)));

    storeMatch: assert property (@(posedge clk)
        storeTrace.valid |-> storeTrace.addr == expStore.addr && storeTrace.data == expStore.data)
        else reportMismatch($sformatf("store dut [%h]=%h model [%h]=%h",
                                      $sampled(storeTrace.addr), $sampled(storeTrace.data),
                                      $sampled(expStore.addr), $sampled(expStore.data)));

    // halt loop never leaves its own address.
    haltHolds: assert property (@(posedge clk) rstN && pc == HaltPc |=> pc == HaltPc)
        else reportMismatch($sformatf("pc left halt address, now %h", $sampled(pc)));

    initial begin
        int pulseAt;
        int atHalt;

        rstN   = 1'b0;
        primed = 1'b0;
        void'($urandom(32'hb7e3_7ad4));
        pulseAt = 20 + int'($urandom % 41);
        @(posedge clk);
        #1 primed = 1'b1;   // pc defined from here on.
        repeat (ResetCycles - 1) @(posedge clk);
        #1 rstN = 1'b1;

        repeat (pulseAt) @(posedge clk);
        #1 rstN = 1'b0;   // mid-run reset.
        repeat (PulseCycles) @(posedge clk);
        #1 rstN = 1'b1;

        atHalt = 0;
        while (atHalt < HaltCycles) begin
            @(posedge clk);
            #1;
            if (pc == HaltPc) begin
                atHalt++;
            end else begin
                atHalt = 0;
            end
        end
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout: the CPU did not settle at its halt address within %0d ns.", WatchdogNs);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- program.hex
// one 32-bit instruction word per line in hex, starting at byte address 0.
// trailing text after // is the assembly for that word.
20010005 // 0x00 addi $1, $0, 5
2002fffd // 0x04 addi $2, $0, -3
00221820 // 0x08 add  $3, $1, $2
00222022 // 0x0c sub  $4, $1, $2
00222824 // 0x10 and  $5, $1, $2
00223025 // 0x14 or   $6, $1, $2
0041382a // 0x18 slt  $7, $2, $1
0022402a // 0x1c slt  $8, $1, $2
ac040008 // 0x20 sw   $4, 8($0)
ac22000b // 0x24 sw   $2, 11($1)
8c090008 // 0x28 lw   $9, 8($0)
8c0a0010 // 0x2c lw   $10, 16($0)
00210020 // 0x30 add  $0, $1, $1
00095820 // 0x34 add  $11, $0, $9
11240001 // 0x38 beq  $9, $4, +1
200c0063 // 0x3c addi $12, $0, 99
10220001 // 0x40 beq  $1, $2, +1
200d0007 // 0x44 addi $13, $0, 7
08000014 // 0x48 j    0x50
200e0001 // 0x4c addi $14, $0, 1
200f8000 // 0x50 addi $15, $0, -32768
00221821 // 0x54 addu (unsupported funct)
fc000000 // 0x58 unsupported opcode
20100003 // 0x5c addi $16, $0, 3
2210ffff // 0x60 addi $16, $16, -1
ac100020 // 0x64 sw   $16, 32($0)
12000001 // 0x68 beq  $16, $0, +1
1000fffc // 0x6c beq  $0, $0, -4
8c110020 // 0x70 lw   $17, 32($0)
00419022 // 0x74 sub  $18, $2, $1
01e2982a // 0x78 slt  $19, $15, $2
0800001f // 0x7c j    0x7c

//--- vlog.f
cpuPkg.sv
alu.sv
regFile.sv
pcUnit.sv
controlUnit.sv
instrMem.sv
dataMem.sv
cpu.sv
tbIsaModel.sv
tbCpu.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - cpuPkg.sv
      - alu.sv
      - regFile.sv
      - pcUnit.sv
      - controlUnit.sv
      - instrMem.sv
      - dataMem.sv
      - cpu.sv
  - target: test
    files:
      - tbIsaModel.sv
      - tbCpu.sv
